// ==== flist.f ====
hw/rob_pkg.sv
hw/rob_table.sv
hw/issue_dispatch.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/cdb_arbiter.sv
hw/rob_subsys_top.sv
dv/tb_clk_gen.sv
dv/rob_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f flist.f --top-module rob_tb -o rob_tb_sim

./obj_dir/rob_tb_sim 2>&1 | tee sim.log

if grep -qF '** FAIL **' sim.log; then
    echo "simulation failed"
    exit 1
fi

if ! grep -qF '** PASS **' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"

// ==== dv/rob_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_tb;

    localparam int unsigned CLK_PERIOD_NS = 4;
    localparam int unsigned DRIVE_DLY     = 1;
    localparam int unsigned N_RANDOM_A    = 300;
    localparam int unsigned N_RANDOM_B    = 200;
    localparam int unsigned FLUSH_BATCH   = 6;
    localparam int unsigned HOLD_CYCLES   = 40;
    localparam int unsigned QUIET_CYCLES  = 20;
    localparam int unsigned ACK_LIMIT     = 200;
    localparam int unsigned WORST_CYCLES  = 60;
    localparam int unsigned DRAIN_LIMIT   = rob_pkg::ROB_DEPTH * WORST_CYCLES;
    localparam int unsigned N_TOTAL       = rob_pkg::ROB_DEPTH + 1 + N_RANDOM_A
                                          + FLUSH_BATCH + N_RANDOM_B;
    localparam int unsigned WATCHDOG_NS   = (N_TOTAL * WORST_CYCLES + 1000) * CLK_PERIOD_NS;

    logic                       clk;
    logic                       arst_n;
    logic                       flush_i;
    logic                       disp_req_i;
    rob_pkg::op_e               disp_op_i;
    logic [rob_pkg::AREG_W-1:0] disp_areg_i;
    logic [rob_pkg::PC_W-1:0]   disp_pc_i;
    logic [rob_pkg::DATA_W-1:0] disp_a_i;
    logic [rob_pkg::DATA_W-1:0] disp_b_i;
    logic                       commit_req_i;
    logic                       disp_ack_o;
    logic                       commit_valid_o;
    logic [rob_pkg::AREG_W-1:0] commit_areg_o;
    logic [rob_pkg::PC_W-1:0]   commit_pc_o;
    logic [rob_pkg::DATA_W-1:0] commit_data_o;

    integer      seed;
    integer      commit_seed;
    logic        commit_en;
    int unsigned accepted;
    int unsigned committed;
    int unsigned discarded;
    logic        ack_prev;
    int unsigned ack_rises;

    // model of the rob with the oldest instruction at the front
    logic [rob_pkg::AREG_W-1:0] exp_areg_q [$];
    logic [rob_pkg::PC_W-1:0]   exp_pc_q   [$];
    logic [rob_pkg::DATA_W-1:0] exp_data_q [$];

    tb_clk_gen u_clk_gen (
        .clk      (clk),
        .arst_n_o (arst_n)
    );

    rob_subsys_top uut (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .flush_i        (flush_i),
        .disp_req_i     (disp_req_i),
        .disp_op_i      (disp_op_i),
        .disp_areg_i    (disp_areg_i),
        .disp_pc_i      (disp_pc_i),
        .disp_a_i       (disp_a_i),
        .disp_b_i       (disp_b_i),
        .commit_req_i   (commit_req_i),
        .disp_ack_o     (disp_ack_o),
        .commit_valid_o (commit_valid_o),
        .commit_areg_o  (commit_areg_o),
        .commit_pc_o    (commit_pc_o),
        .commit_data_o  (commit_data_o)
    );

    ////////////////////////////////////////////////////////////
    // reference model and checking
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] expected_result(input rob_pkg::op_e op,
                                                    input logic [31:0] a,
                                                    input logic [31:0] b);
        logic [63:0] prod;
        begin
            prod = {32'b0, a} * {32'b0, b};
            case (op)
                rob_pkg::OP_ADD: expected_result = a + b;
                rob_pkg::OP_SUB: expected_result = a - b;
                rob_pkg::OP_XOR: expected_result = a ^ b;
                default:         expected_result = prod[31:0];
            endcase
        end
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        begin
            if (got !== exp) begin
                $display("error: t=%0t ns %s is %h, expected %h", $time, what, got, exp);
                $display("** FAIL **");
                $fatal(1, "stopped at first mismatch");
            end
        end
    endtask

    task automatic abort_run(input string why);
        begin
            $display("%s (t=%0t ns)", why, $time);
            $display("** FAIL **");
            $fatal(1, "run aborted");
        end
    endtask

    // rising edges of the dispatch ack taken straight from the port
    always @(negedge clk) begin
        if (disp_ack_o === 1'b1 && ack_prev !== 1'b1) begin
            ack_rises++;
        end
        ack_prev = disp_ack_o;
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////
    task automatic step_cycle();
        begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    // commit_en only changes on the falling edge
    task automatic set_commit_enable(input logic en);
        begin
            @(negedge clk);
            commit_en = en;
            step_cycle();
        end
    endtask

    task automatic raise_request(input rob_pkg::op_e op);
        logic [31:0] rnd;
        begin
            rnd         = $random(seed);
            disp_op_i   = op;
            disp_areg_i = rnd[4:0];
            disp_pc_i   = $random(seed);
            disp_a_i    = $random(seed);
            disp_b_i    = $random(seed);
            // small operands now and then
            if (rnd[9:8] == 2'b00) begin
                disp_b_i = disp_b_i & 32'h0000_00ff;
            end
            disp_req_i = 1'b1;
        end
    endtask

    // accepted instruction goes into the model at the ack
    task automatic await_ack(input int unsigned limit);
        int unsigned waited;
        begin
            waited = 0;
            while (disp_ack_o !== 1'b1) begin
                if (waited >= limit) abort_run("dispatch request was never acknowledged");
                else begin
                    step_cycle();
                    waited++;
                end
            end
            exp_areg_q.push_back(disp_areg_i);
            exp_pc_q.push_back(disp_pc_i);
            exp_data_q.push_back(expected_result(disp_op_i, disp_a_i, disp_b_i));
            accepted++;
            disp_req_i = 1'b0;
            waited     = 0;
            while (disp_ack_o !== 1'b0) begin
                if (waited >= limit) abort_run("dispatch ack did not fall after req dropped");
                else begin
                    step_cycle();
                    waited++;
                end
            end
        end
    endtask

    task automatic send_instr(input rob_pkg::op_e op);
        begin
            raise_request(op);
            await_ack(ACK_LIMIT);
        end
    endtask

    task automatic send_random();
        logic [31:0] rnd;
        begin
            rnd = $random(seed);
            send_instr(rob_pkg::op_e'(rnd[1:0]));
        end
    endtask

    task automatic random_traffic(input int unsigned n);
        int unsigned i;
        logic [31:0] rnd;
        begin
            set_commit_enable(1'b1);
            for (i = 0; i < n; i++) begin
                rnd = $random(seed);
                repeat (rnd[1:0]) step_cycle();
                send_random();
            end
        end
    endtask

    task automatic drain_rob();
        int unsigned waited;
        begin
            set_commit_enable(1'b1);
            waited = 0;
            while (exp_data_q.size() != 0) begin
                if (waited >= DRAIN_LIMIT) abort_run("rob did not drain, commits stalled");
                else begin
                    step_cycle();
                    waited++;
                end
            end
            repeat (2) step_cycle();
            check_value("commit_valid_o after drain", commit_valid_o, 1'b0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed phases
    ////////////////////////////////////////////////////////////
    // fill all entries with commits held back so that one more must wait
    task automatic fill_and_block();
        int unsigned i;
        begin
            set_commit_enable(1'b0);
            for (i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
                send_random();
            end
            raise_request(rob_pkg::OP_ADD);
            repeat (HOLD_CYCLES) begin
                step_cycle();
                check_value("disp_ack_o with rob full", disp_ack_o, 1'b0);
            end
            set_commit_enable(1'b1);
            await_ack(ACK_LIMIT);
        end
    endtask

    // last one is a multiply so it is still computing at the flush
    task automatic flush_in_flight();
        int unsigned i;
        begin
            set_commit_enable(1'b0);
            for (i = 0; i < FLUSH_BATCH - 1; i++) begin
                send_random();
            end
            send_instr(rob_pkg::OP_MUL);
            flush_i = 1'b1;
            step_cycle();
            flush_i = 1'b0;
            discarded += exp_data_q.size();
            exp_areg_q.delete();
            exp_pc_q.delete();
            exp_data_q.delete();
            repeat (QUIET_CYCLES) begin
                check_value("commit_valid_o after flush", commit_valid_o, 1'b0);
                check_value("disp_ack_o after flush", disp_ack_o, 1'b0);
                step_cycle();
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // commit stage with random back-pressure
    ////////////////////////////////////////////////////////////
    initial begin : commit_stage
        logic [31:0] rnd;
        commit_req_i = 1'b0;
        forever begin
            step_cycle();
            commit_req_i = 1'b0;
            rnd          = $random(commit_seed);
            if (commit_en && commit_valid_o === 1'b1 && rnd[1:0] != 2'b00) begin
                if (exp_data_q.size() == 0) begin
                    abort_run("commit offered with no instruction outstanding");
                end else begin
                    check_value("commit_areg_o", commit_areg_o, exp_areg_q[0]);
                    check_value("commit_pc_o", commit_pc_o, exp_pc_q[0]);
                    check_value("commit_data_o", commit_data_o, exp_data_q[0]);
                    void'(exp_areg_q.pop_front());
                    void'(exp_pc_q.pop_front());
                    void'(exp_data_q.pop_front());
                    committed++;
                    commit_req_i = 1'b1;
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run stopped making progress", WATCHDOG_NS);
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    initial begin : main_seq
        seed        = 32'hba78;
        commit_seed = $random(seed);
        commit_en   = 1'b0;
        accepted    = 0;
        committed   = 0;
        discarded   = 0;
        ack_prev    = 1'b0;
        ack_rises   = 0;
        flush_i     = 1'b0;
        disp_req_i  = 1'b0;
        disp_op_i   = rob_pkg::OP_ADD;
        disp_areg_i = '0;
        disp_pc_i   = '0;
        disp_a_i    = '0;
        disp_b_i    = '0;

        wait (arst_n === 1'b1);
        step_cycle();
        check_value("disp_ack_o after reset", disp_ack_o, 1'b0);
        check_value("commit_valid_o after reset", commit_valid_o, 1'b0);

        fill_and_block();
        drain_rob();
        random_traffic(N_RANDOM_A);
        drain_rob();
        flush_in_flight();
        random_traffic(N_RANDOM_B);
        drain_rob();

        // one ack per request, nothing extra at the port
        check_value("acks seen at the dut port", ack_rises, accepted);
        $display("committed %0d, discarded by flush %0d", committed, discarded);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic arst_n_o
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held over the first three rising edges
    initial begin
        arst_n_o = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        arst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== hw/rob_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_subsys_top (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       flush_i,
    input  logic                       disp_req_i,
    input  rob_pkg::op_e               disp_op_i,
    input  logic [rob_pkg::AREG_W-1:0] disp_areg_i,
    input  logic [rob_pkg::PC_W-1:0]   disp_pc_i,
    input  logic [rob_pkg::DATA_W-1:0] disp_a_i,
    input  logic [rob_pkg::DATA_W-1:0] disp_b_i,
    input  logic                       commit_req_i,
    output logic                       disp_ack_o,
    output logic                       commit_valid_o,
    output logic [rob_pkg::AREG_W-1:0] commit_areg_o,
    output logic [rob_pkg::PC_W-1:0]   commit_pc_o,
    output logic [rob_pkg::DATA_W-1:0] commit_data_o
);

    // dispatch to rob
    logic                          rob_full;
    logic [rob_pkg::ROB_IDX_W-1:0] alloc_id;
    logic                          alloc_valid;
    logic [rob_pkg::AREG_W-1:0]    alloc_areg;
    logic [rob_pkg::PC_W-1:0]      alloc_pc;

    // dispatch to units
    logic                          alu_issue;
    logic                          mul_issue;
    logic                          alu_busy;
    logic                          mul_busy;
    rob_pkg::op_e                  issue_op;
    logic [rob_pkg::DATA_W-1:0]    issue_a;
    logic [rob_pkg::DATA_W-1:0]    issue_b;
    logic [rob_pkg::ROB_IDX_W-1:0] issue_id;

    // units to arbiter
    logic                          alu_cdb_req;
    logic                          alu_cdb_ack;
    logic [rob_pkg::ROB_IDX_W-1:0] alu_cdb_id;
    logic [rob_pkg::DATA_W-1:0]    alu_cdb_data;
    logic                          mul_cdb_req;
    logic                          mul_cdb_ack;
    logic [rob_pkg::ROB_IDX_W-1:0] mul_cdb_id;
    logic [rob_pkg::DATA_W-1:0]    mul_cdb_data;

    // cdb write into the rob
    logic                          cdb_valid;
    logic [rob_pkg::ROB_IDX_W-1:0] cdb_id;
    logic [rob_pkg::DATA_W-1:0]    cdb_data;

    issue_dispatch u_dispatch (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .flush_i       (flush_i),
        .disp_req_i    (disp_req_i),
        .disp_op_i     (disp_op_i),
        .disp_areg_i   (disp_areg_i),
        .disp_pc_i     (disp_pc_i),
        .disp_a_i      (disp_a_i),
        .disp_b_i      (disp_b_i),
        .rob_full_i    (rob_full),
        .alloc_id_i    (alloc_id),
        .alu_busy_i    (alu_busy),
        .mul_busy_i    (mul_busy),
        .disp_ack_o    (disp_ack_o),
        .alloc_valid_o (alloc_valid),
        .alloc_areg_o  (alloc_areg),
        .alloc_pc_o    (alloc_pc),
        .alu_issue_o   (alu_issue),
        .mul_issue_o   (mul_issue),
        .issue_op_o    (issue_op),
        .issue_a_o     (issue_a),
        .issue_b_o     (issue_b),
        .issue_id_o    (issue_id)
    );

    alu_unit u_alu (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .flush_i    (flush_i),
        .issue_i    (alu_issue),
        .op_i       (issue_op),
        .a_i        (issue_a),
        .b_i        (issue_b),
        .id_i       (issue_id),
        .cdb_ack_i  (alu_cdb_ack),
        .busy_o     (alu_busy),
        .cdb_req_o  (alu_cdb_req),
        .cdb_id_o   (alu_cdb_id),
        .cdb_data_o (alu_cdb_data)
    );

    mul_unit u_mul (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .flush_i    (flush_i),
        .issue_i    (mul_issue),
        .a_i        (issue_a),
        .b_i        (issue_b),
        .id_i       (issue_id),
        .cdb_ack_i  (mul_cdb_ack),
        .busy_o     (mul_busy),
        .cdb_req_o  (mul_cdb_req),
        .cdb_id_o   (mul_cdb_id),
        .cdb_data_o (mul_cdb_data)
    );

    cdb_arbiter u_arb (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .alu_req_i   (alu_cdb_req),
        .alu_id_i    (alu_cdb_id),
        .alu_data_i  (alu_cdb_data),
        .mul_req_i   (mul_cdb_req),
        .mul_id_i    (mul_cdb_id),
        .mul_data_i  (mul_cdb_data),
        .alu_ack_o   (alu_cdb_ack),
        .mul_ack_o   (mul_cdb_ack),
        .cdb_valid_o (cdb_valid),
        .cdb_id_o    (cdb_id),
        .cdb_data_o  (cdb_data)
    );

    rob_table u_rob (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .alloc_valid_i  (alloc_valid),
        .alloc_areg_i   (alloc_areg),
        .alloc_pc_i     (alloc_pc),
        .cdb_valid_i    (cdb_valid),
        .cdb_id_i       (cdb_id),
        .cdb_data_i     (cdb_data),
        .commit_req_i   (commit_req_i),
        .alloc_id_o     (alloc_id),
        .rob_full_o     (rob_full),
        .commit_valid_o (commit_valid_o),
        .commit_areg_o  (commit_areg_o),
        .commit_pc_o    (commit_pc_o),
        .commit_data_o  (commit_data_o)
    );

endmodule

`default_nettype wire

// ==== hw/cdb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          flush_i,
    input  logic                          alu_req_i,
    input  logic [rob_pkg::ROB_IDX_W-1:0] alu_id_i,
    input  logic [rob_pkg::DATA_W-1:0]    alu_data_i,
    input  logic                          mul_req_i,
    input  logic [rob_pkg::ROB_IDX_W-1:0] mul_id_i,
    input  logic [rob_pkg::DATA_W-1:0]    mul_data_i,
    output logic                          alu_ack_o,
    output logic                          mul_ack_o,
    output logic                          cdb_valid_o,
    output logic [rob_pkg::ROB_IDX_W-1:0] cdb_id_o,
    output logic [rob_pkg::DATA_W-1:0]    cdb_data_o
);

    logic prio_mul_q;
    logic free;
    logic grant_alu;
    logic grant_mul;

    // new grant only once the previous handshake has fully closed
    assign free      = !alu_ack_o && !mul_ack_o;
    assign grant_alu = free && alu_req_i && (!mul_req_i || !prio_mul_q);
    assign grant_mul = free && mul_req_i && !grant_alu;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            alu_ack_o   <= 1'b0;
            mul_ack_o   <= 1'b0;
            cdb_valid_o <= 1'b0;
            prio_mul_q  <= 1'b0;
        end else if (flush_i) begin
            alu_ack_o   <= 1'b0;
            mul_ack_o   <= 1'b0;
            cdb_valid_o <= 1'b0;
            prio_mul_q  <= 1'b0;
        end else begin
            cdb_valid_o <= grant_alu || grant_mul;
            if (grant_alu) begin
                alu_ack_o  <= 1'b1;
                prio_mul_q <= 1'b1;
            end else if (!alu_req_i) begin
                alu_ack_o <= 1'b0;
            end
            if (grant_mul) begin
                mul_ack_o  <= 1'b1;
                prio_mul_q <= 1'b0;
            end else if (!mul_req_i) begin
                mul_ack_o <= 1'b0;
            end
        end
    end

    // cdb payload follows the winner
    always_ff @(posedge clk) begin
        if (grant_alu) begin
            cdb_id_o   <= alu_id_i;
            cdb_data_o <= alu_data_i;
        end else if (grant_mul) begin
            cdb_id_o   <= mul_id_i;
            cdb_data_o <= mul_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          flush_i,
    input  logic                          issue_i,
    input  logic [rob_pkg::DATA_W-1:0]    a_i,
    input  logic [rob_pkg::DATA_W-1:0]    b_i,
    input  logic [rob_pkg::ROB_IDX_W-1:0] id_i,
    input  logic                          cdb_ack_i,
    output logic                          busy_o,
    output logic                          cdb_req_o,
    output logic [rob_pkg::ROB_IDX_W-1:0] cdb_id_o,
    output logic [rob_pkg::DATA_W-1:0]    cdb_data_o
);

    rob_pkg::mul_state_e           state_q;
    logic [rob_pkg::MUL_CNT_W-1:0] step_q;
    logic [rob_pkg::DATA_W-1:0]    mcand_q;
    logic [rob_pkg::DATA_W-1:0]    mplier_q;
    logic [rob_pkg::DATA_W-1:0]    acc_q;
    logic [rob_pkg::ROB_IDX_W-1:0] id_q;

    logic [rob_pkg::DATA_W-1:0] mcand;
    logic [rob_pkg::DATA_W-1:0] mplier;
    logic [rob_pkg::DATA_W-1:0] acc_next;

    // first step runs on the issue cycle itself
    assign mcand    = issue_i ? a_i : mcand_q;
    assign mplier   = issue_i ? b_i : mplier_q;
    assign acc_next = (issue_i ? '0 : acc_q)
                    + mcand * rob_pkg::DATA_W'(mplier[3:0]);

    ////////////////////////////////////////////////////////////
    // sequencer and cdb handshake
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= rob_pkg::MUL_IDLE;
            step_q  <= '0;
        end else if (flush_i) begin
            state_q <= rob_pkg::MUL_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                rob_pkg::MUL_IDLE: begin
                    step_q <= rob_pkg::MUL_CNT_W'(1);
                    if (issue_i) state_q <= rob_pkg::MUL_COMPUTE;
                end
                rob_pkg::MUL_COMPUTE: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == rob_pkg::MUL_CNT_W'(rob_pkg::MUL_STEPS - 1)) begin
                        state_q <= rob_pkg::MUL_REQ;
                    end
                end
                rob_pkg::MUL_REQ: if (cdb_ack_i) state_q <= rob_pkg::MUL_REL;
                rob_pkg::MUL_REL: if (!cdb_ack_i) state_q <= rob_pkg::MUL_IDLE;
                default:          state_q <= rob_pkg::MUL_IDLE;
            endcase
        end
    end

    // shift-and-add datapath, low 32 bits kept
    always_ff @(posedge clk) begin
        if (issue_i || state_q == rob_pkg::MUL_COMPUTE) begin
            mcand_q  <= mcand << 4;
            mplier_q <= mplier >> 4;
            acc_q    <= acc_next;
        end
        if (issue_i) begin
            id_q <= id_i;
        end
    end

    assign busy_o     = (state_q != rob_pkg::MUL_IDLE);
    assign cdb_req_o  = (state_q == rob_pkg::MUL_REQ);
    assign cdb_id_o   = id_q;
    assign cdb_data_o = acc_q;

endmodule

`default_nettype wire

// ==== hw/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          flush_i,
    input  logic                          issue_i,
    input  rob_pkg::op_e                  op_i,
    input  logic [rob_pkg::DATA_W-1:0]    a_i,
    input  logic [rob_pkg::DATA_W-1:0]    b_i,
    input  logic [rob_pkg::ROB_IDX_W-1:0] id_i,
    input  logic                          cdb_ack_i,
    output logic                          busy_o,
    output logic                          cdb_req_o,
    output logic [rob_pkg::ROB_IDX_W-1:0] cdb_id_o,
    output logic [rob_pkg::DATA_W-1:0]    cdb_data_o
);

    rob_pkg::alu_state_e           state_q;
    logic [rob_pkg::DATA_W-1:0]    result_d;
    logic [rob_pkg::DATA_W-1:0]    result_q;
    logic [rob_pkg::ROB_IDX_W-1:0] id_q;

    always_comb begin
        case (op_i)
            rob_pkg::OP_SUB: result_d = a_i - b_i;
            rob_pkg::OP_XOR: result_d = a_i ^ b_i;
            default:         result_d = a_i + b_i;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // cdb requester side
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= rob_pkg::ALU_IDLE;
        end else if (flush_i) begin
            state_q <= rob_pkg::ALU_IDLE;
        end else begin
            case (state_q)
                rob_pkg::ALU_IDLE: if (issue_i) state_q <= rob_pkg::ALU_REQ;
                rob_pkg::ALU_REQ:  if (cdb_ack_i) state_q <= rob_pkg::ALU_REL;
                rob_pkg::ALU_REL:  if (!cdb_ack_i) state_q <= rob_pkg::ALU_IDLE;
                default:           state_q <= rob_pkg::ALU_IDLE;
            endcase
        end
    end

    // result captured at issue, held through the handshake
    always_ff @(posedge clk) begin
        if (issue_i) begin
            result_q <= result_d;
            id_q     <= id_i;
        end
    end

    assign busy_o     = (state_q != rob_pkg::ALU_IDLE);
    assign cdb_req_o  = (state_q == rob_pkg::ALU_REQ);
    assign cdb_id_o   = id_q;
    assign cdb_data_o = result_q;

endmodule

`default_nettype wire

// ==== hw/issue_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_dispatch (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          flush_i,
    input  logic                          disp_req_i,
    input  rob_pkg::op_e                  disp_op_i,
    input  logic [rob_pkg::AREG_W-1:0]    disp_areg_i,
    input  logic [rob_pkg::PC_W-1:0]      disp_pc_i,
    input  logic [rob_pkg::DATA_W-1:0]    disp_a_i,
    input  logic [rob_pkg::DATA_W-1:0]    disp_b_i,
    input  logic                          rob_full_i,
    input  logic [rob_pkg::ROB_IDX_W-1:0] alloc_id_i,
    input  logic                          alu_busy_i,
    input  logic                          mul_busy_i,
    output logic                          disp_ack_o,
    output logic                          alloc_valid_o,
    output logic [rob_pkg::AREG_W-1:0]    alloc_areg_o,
    output logic [rob_pkg::PC_W-1:0]      alloc_pc_o,
    output logic                          alu_issue_o,
    output logic                          mul_issue_o,
    output rob_pkg::op_e                  issue_op_o,
    output logic [rob_pkg::DATA_W-1:0]    issue_a_o,
    output logic [rob_pkg::DATA_W-1:0]    issue_b_o,
    output logic [rob_pkg::ROB_IDX_W-1:0] issue_id_o
);

    logic ack_q;
    logic is_mul;
    logic unit_busy;
    logic accept;

    // multiplies go to the multiplier, the rest to the alu
    assign is_mul     = (disp_op_i == rob_pkg::OP_MUL);
    assign unit_busy  = is_mul ? mul_busy_i : alu_busy_i;
    assign accept     = disp_req_i && !ack_q && !rob_full_i && !unit_busy;
    assign disp_ack_o = ack_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q         <= 1'b0;
            alloc_valid_o <= 1'b0;
            alu_issue_o   <= 1'b0;
            mul_issue_o   <= 1'b0;
        end else if (flush_i) begin
            ack_q         <= 1'b0;
            alloc_valid_o <= 1'b0;
            alu_issue_o   <= 1'b0;
            mul_issue_o   <= 1'b0;
        end else begin
            alloc_valid_o <= accept;
            alu_issue_o   <= accept && !is_mul;
            mul_issue_o   <= accept && is_mul;
            // ack held until the source releases req
            if (accept) begin
                ack_q <= 1'b1;
            end else if (!disp_req_i) begin
                ack_q <= 1'b0;
            end
        end
    end

    // id is the rob tail, still unchanged when the pulse reaches the rob
    always_ff @(posedge clk) begin
        if (accept) begin
            alloc_areg_o <= disp_areg_i;
            alloc_pc_o   <= disp_pc_i;
            issue_op_o   <= disp_op_i;
            issue_a_o    <= disp_a_i;
            issue_b_o    <= disp_b_i;
            issue_id_o   <= alloc_id_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rob_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_table (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          flush_i,
    input  logic                          alloc_valid_i,
    input  logic [rob_pkg::AREG_W-1:0]    alloc_areg_i,
    input  logic [rob_pkg::PC_W-1:0]      alloc_pc_i,
    input  logic                          cdb_valid_i,
    input  logic [rob_pkg::ROB_IDX_W-1:0] cdb_id_i,
    input  logic [rob_pkg::DATA_W-1:0]    cdb_data_i,
    input  logic                          commit_req_i,
    output logic [rob_pkg::ROB_IDX_W-1:0] alloc_id_o,
    output logic                          rob_full_o,
    output logic                          commit_valid_o,
    output logic [rob_pkg::AREG_W-1:0]    commit_areg_o,
    output logic [rob_pkg::PC_W-1:0]      commit_pc_o,
    output logic [rob_pkg::DATA_W-1:0]    commit_data_o
);

    // entry payload
    logic [rob_pkg::AREG_W-1:0] areg_mem [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::PC_W-1:0]   pc_mem   [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::DATA_W-1:0] data_mem [rob_pkg::ROB_DEPTH];

    // completion pair, entry done while the bits differ
    logic [rob_pkg::ROB_DEPTH-1:0] disp_bit_q;
    logic [rob_pkg::ROB_DEPTH-1:0] cdb_bit_q;

    logic [rob_pkg::ROB_IDX_W-1:0] head_q;
    logic [rob_pkg::ROB_IDX_W-1:0] tail_q;
    logic [rob_pkg::ROB_IDX_W:0]   count_q;
    logic                          commit_fire;

    assign alloc_id_o  = tail_q;
    assign rob_full_o  = (count_q == (rob_pkg::ROB_IDX_W+1)'(rob_pkg::ROB_DEPTH));
    assign commit_fire = commit_req_i & commit_valid_o;

    ////////////////////////////////////////////////////////////
    // commit read port
    ////////////////////////////////////////////////////////////
    assign commit_valid_o = (count_q != '0) && (disp_bit_q[head_q] ^ cdb_bit_q[head_q]);
    assign commit_areg_o  = areg_mem[head_q];
    assign commit_pc_o    = pc_mem[head_q];
    assign commit_data_o  = data_mem[head_q];

    ////////////////////////////////////////////////////////////
    // pointers, count, toggle bits
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q     <= '0;
            tail_q     <= '0;
            count_q    <= '0;
            disp_bit_q <= '0;
            cdb_bit_q  <= '0;
        end else if (flush_i) begin
            head_q     <= '0;
            tail_q     <= '0;
            count_q    <= '0;
            disp_bit_q <= '0;
            cdb_bit_q  <= '0;
        end else begin
            if (alloc_valid_i) begin
                tail_q <= tail_q + 1'b1;
                // match the cdb bit, i.e. flip a retired entry back to pending
                disp_bit_q[tail_q] <= cdb_bit_q[tail_q];
            end
            if (cdb_valid_i) begin
                cdb_bit_q[cdb_id_i] <= ~disp_bit_q[cdb_id_i];
            end
            if (commit_fire) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc_valid_i, commit_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // payload writes, areg/pc at allocation and data from the cdb
    always_ff @(posedge clk) begin
        if (alloc_valid_i) begin
            areg_mem[tail_q] <= alloc_areg_i;
            pc_mem[tail_q]   <= alloc_pc_i;
        end
        if (cdb_valid_i) begin
            data_mem[cdb_id_i] <= cdb_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rob_pkg.sv ====
`default_nettype none

package rob_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////
    localparam int ROB_DEPTH = 16;
    localparam int ROB_IDX_W = 4;
    localparam int DATA_W    = 32;
    localparam int AREG_W    = 5;
    localparam int PC_W      = 32;

    // four multiplier bits per step
    localparam int MUL_STEPS = 8;
    localparam int MUL_CNT_W = $clog2(MUL_STEPS);

    ////////////////////////////////////////////////////////////
    // opcodes and unit states
    ////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_XOR = 2'd2,
        OP_MUL = 2'd3
    } op_e;

    typedef enum logic [1:0] {
        ALU_IDLE = 2'd0,
        ALU_REQ  = 2'd1,
        ALU_REL  = 2'd2
    } alu_state_e;

    typedef enum logic [1:0] {
        MUL_IDLE    = 2'd0,
        MUL_COMPUTE = 2'd1,
        MUL_REQ     = 2'd2,
        MUL_REL     = 2'd3
    } mul_state_e;

endpackage

`default_nettype wire
